/* source/periph_pkg.sv */
// *********************************************************
// Peripheral subsystem definitions: address map, register
// indices and bus widths shared by the bridge and peripherals
// *********************************************************

package periph_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  // Peripheral select, address bits 7 to 4
  localparam logic [3:0] SEL_INTC  = 4'd0;
  localparam logic [3:0] SEL_GPIO  = 4'd1;
  localparam logic [3:0] SEL_TIMER = 4'd2;

  // Register index, address bits 3 to 2
  typedef logic [1:0] reg_idx_t;

  // GPIO registers
  localparam reg_idx_t REG_GPIO_OUT    = 2'd0;
  localparam reg_idx_t REG_GPIO_OE     = 2'd1;
  localparam reg_idx_t REG_GPIO_IN     = 2'd2;
  localparam reg_idx_t REG_GPIO_IRQ_EN = 2'd3;

  // Timer registers
  localparam reg_idx_t REG_TMR_CTRL  = 2'd0;
  localparam reg_idx_t REG_TMR_CMP   = 2'd1;
  localparam reg_idx_t REG_TMR_COUNT = 2'd2;

  // Interrupt controller registers
  localparam reg_idx_t REG_INTC_PENDING = 2'd0;
  localparam reg_idx_t REG_INTC_ENABLE  = 2'd1;
  localparam reg_idx_t REG_INTC_CLAIM   = 2'd2;

endpackage : periph_pkg

/* source/periph_bridge.sv */
// *********************************************************
// Register port bridge: four-phase req/ack handshake, address
// decode into peripheral strobes and read-data return
// *********************************************************

`timescale 1ns/10ps

module periph_bridge
  import periph_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Bus master side
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  err_o,
  output logic                  ack_o,

  // Peripheral side
  output logic                  intc_sel_o,
  output logic                  gpio_sel_o,
  output logic                  tmr_sel_o,
  output logic                  we_o,
  output reg_idx_t              idx_o,
  output logic [DATA_WIDTH-1:0] wdata_o,
  input  logic [DATA_WIDTH-1:0] intc_rdata_i,
  input  logic [DATA_WIDTH-1:0] gpio_rdata_i,
  input  logic [DATA_WIDTH-1:0] tmr_rdata_i
);

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACCESS = 2'd1,
    ACK    = 2'd2
  } state_t;

  state_t                state_q;
  state_t                state_d;
  logic [3:0]            sel_field;
  logic                  hit_intc;
  logic                  hit_gpio;
  logic                  hit_tmr;
  logic                  mapped;
  logic                  in_access;
  logic [DATA_WIDTH-1:0] sel_rdata;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic                  err_q;

  // Address decode
  assign sel_field = addr_i[ADDR_WIDTH-1:ADDR_WIDTH-4];
  assign hit_intc  = (sel_field == SEL_INTC);
  assign hit_gpio  = (sel_field == SEL_GPIO);
  assign hit_tmr   = (sel_field == SEL_TIMER);
  assign mapped    = hit_intc | hit_gpio | hit_tmr;
  assign in_access = (state_q == ACCESS);

  // One-cycle strobes, none for an unmapped address
  assign intc_sel_o = in_access & hit_intc;
  assign gpio_sel_o = in_access & hit_gpio;
  assign tmr_sel_o  = in_access & hit_tmr;
  assign we_o       = we_i;
  assign idx_o      = addr_i[3:2];
  assign wdata_o    = wdata_i;

  always_comb begin
    sel_rdata = '0;
    if (hit_intc) begin
      sel_rdata = intc_rdata_i;
    end else if (hit_gpio) begin
      sel_rdata = gpio_rdata_i;
    end else if (hit_tmr) begin
      sel_rdata = tmr_rdata_i;
    end
  end

  // Handshake FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = ACCESS;
      ACCESS:  state_d = ACK;
      ACK:     if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (in_access) begin
        rdata_q <= sel_rdata;
        err_q   <= ~mapped;
      end
    end
  end

  assign ack_o   = (state_q == ACK);
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  // Master must still hold its request when the ack arrives
  a_ack_needs_req : assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> req_i);

  a_one_strobe : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({intc_sel_o, gpio_sel_o, tmr_sel_o}));

endmodule : periph_bridge

/* source/periph_timer.sv */
// *********************************************************
// Compare timer with a free-running counter that wraps to
// zero on reaching the compare value and pulses an expiry
// *********************************************************

`timescale 1ns/10ps

module periph_timer
  import periph_pkg::*;
#(
  parameter int TIMER_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  sel_i,
  input  logic                  we_i,
  input  reg_idx_t              idx_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  expired_o
);

  logic                   en_q;
  logic [TIMER_WIDTH-1:0] cmp_q;
  logic [TIMER_WIDTH-1:0] count_q;
  logic                   wr_ctrl;
  logic                   wr_cmp;
  logic                   wr_count;

  assign wr_ctrl  = sel_i & we_i & (idx_i == REG_TMR_CTRL);
  assign wr_cmp   = sel_i & we_i & (idx_i == REG_TMR_CMP);
  assign wr_count = sel_i & we_i & (idx_i == REG_TMR_COUNT);

  // Match pulses in the same cycle the counter wraps
  assign expired_o = en_q & (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q    <= 1'b0;
      cmp_q   <= '0;
      count_q <= '0;
    end else begin
      if (wr_ctrl) begin
        en_q <= wdata_i[0];
      end
      if (wr_cmp) begin
        cmp_q <= wdata_i[TIMER_WIDTH-1:0];
      end
      // Software write overrides counting
      if (wr_count) begin
        count_q <= wdata_i[TIMER_WIDTH-1:0];
      end else if (expired_o) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (idx_i)
      REG_TMR_CTRL:  rdata_o = DATA_WIDTH'(en_q);
      REG_TMR_CMP:   rdata_o = DATA_WIDTH'(cmp_q);
      REG_TMR_COUNT: rdata_o = DATA_WIDTH'(count_q);
      default:       rdata_o = '0;
    endcase
  end

  a_expired_enabled : assert property (@(posedge clk_i) disable iff (reset_i)
    expired_o |-> en_q);

endmodule : periph_timer

/* source/periph_gpio.sv */
// *********************************************************
// GPIO block: output and output-enable registers, two-flop
// input synchronizer and rising-edge interrupt pulses
// *********************************************************

`timescale 1ns/10ps

module periph_gpio
  import periph_pkg::*;
#(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  sel_i,
  input  logic                  we_i,
  input  reg_idx_t              idx_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,

  // Pins
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,

  // One pulse per enabled rising edge
  output logic [GPIO_WIDTH-1:0] edge_o
);

  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] oe_q;
  logic [GPIO_WIDTH-1:0] irq_en_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] prev_q;
  logic [GPIO_WIDTH-1:0] edge_q;
  logic                  wr_en;

  assign wr_en = sel_i & we_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      irq_en_q <= '0;
    end else if (wr_en) begin
      case (idx_i)
        REG_GPIO_OUT:    out_q    <= wdata_i[GPIO_WIDTH-1:0];
        REG_GPIO_OE:     oe_q     <= wdata_i[GPIO_WIDTH-1:0];
        REG_GPIO_IRQ_EN: irq_en_q <= wdata_i[GPIO_WIDTH-1:0];
        default:         ;
      endcase
    end
  end

  // Synchronizer, then edge detect one stage later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      edge_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      edge_q  <= sync2_q & ~prev_q & irq_en_q;
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign edge_o    = edge_q;

  always_comb begin
    case (idx_i)
      REG_GPIO_OUT:    rdata_o = DATA_WIDTH'(out_q);
      REG_GPIO_OE:     rdata_o = DATA_WIDTH'(oe_q);
      REG_GPIO_IN:     rdata_o = DATA_WIDTH'(sync2_q);
      REG_GPIO_IRQ_EN: rdata_o = DATA_WIDTH'(irq_en_q);
      default:         rdata_o = '0;
    endcase
  end

endmodule : periph_gpio

/* source/periph_intc.sv */
// *********************************************************
// Interrupt controller with pending and enable bits per
// source, a lowest-number claim register and the irq line
// *********************************************************

`timescale 1ns/10ps

module periph_intc
  import periph_pkg::*;
#(
  parameter int NUM_SRC = 9
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  sel_i,
  input  logic                  we_i,
  input  reg_idx_t              idx_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  irq_o,
  input  logic [NUM_SRC-1:0]    src_i
);

  logic [NUM_SRC-1:0]    pending_q;
  logic [NUM_SRC-1:0]    enable_q;
  logic [NUM_SRC-1:0]    active;
  logic [NUM_SRC-1:0]    claim_mask;
  logic [NUM_SRC-1:0]    clear_mask;
  logic [DATA_WIDTH-1:0] claim_id;
  logic                  wr_pending;
  logic                  wr_enable;
  logic                  rd_claim;

  assign active     = pending_q & enable_q;
  assign wr_pending = sel_i & we_i & (idx_i == REG_INTC_PENDING);
  assign wr_enable  = sel_i & we_i & (idx_i == REG_INTC_ENABLE);
  assign rd_claim   = sel_i & ~we_i & (idx_i == REG_INTC_CLAIM);

  // Scan downwards so the lowest active source is kept
  always_comb begin
    claim_id   = '0;
    claim_mask = '0;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id      = DATA_WIDTH'(i + 1);
        claim_mask    = '0;
        claim_mask[i] = 1'b1;
      end
    end
  end

  always_comb begin
    clear_mask = '0;
    if (wr_pending) begin
      clear_mask = wdata_i[NUM_SRC-1:0];
    end else if (rd_claim) begin
      clear_mask = claim_mask;
    end
  end

  // A new source pulse wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | src_i;
      if (wr_enable) begin
        enable_q <= wdata_i[NUM_SRC-1:0];
      end
    end
  end

  assign irq_o = |active;

  always_comb begin
    case (idx_i)
      REG_INTC_PENDING: rdata_o = DATA_WIDTH'(pending_q);
      REG_INTC_ENABLE:  rdata_o = DATA_WIDTH'(enable_q);
      REG_INTC_CLAIM:   rdata_o = claim_id;
      default:          rdata_o = '0;
    endcase
  end

  a_irq_has_claim : assert property (@(posedge clk_i) disable iff (reset_i)
    irq_o |-> claim_id != '0);

endmodule : periph_intc

/* source/peripheral_subsystem.sv */
// *********************************************************
// Peripheral subsystem top: bridge, GPIO, compare timer and
// interrupt controller behind one req/ack register port
// *********************************************************

`timescale 1ns/10ps

module peripheral_subsystem
  import periph_pkg::*;
#(
  parameter int GPIO_WIDTH  = 8,
  parameter int TIMER_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Register port
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  err_o,
  output logic                  ack_o,

  // Pins and interrupt
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  irq_o
);

  localparam int NUM_SRC = GPIO_WIDTH + 1;

  logic                  intc_sel;
  logic                  gpio_sel;
  logic                  tmr_sel;
  logic                  periph_we;
  reg_idx_t              periph_idx;
  logic [DATA_WIDTH-1:0] periph_wdata;
  logic [DATA_WIDTH-1:0] intc_rdata;
  logic [DATA_WIDTH-1:0] gpio_rdata;
  logic [DATA_WIDTH-1:0] tmr_rdata;
  logic                  tmr_expired;
  logic [GPIO_WIDTH-1:0] gpio_edge;
  logic [NUM_SRC-1:0]    intc_src;

  // Timer is source 0, pin n is source n+1
  assign intc_src = {gpio_edge, tmr_expired};

  periph_bridge i_periph_bridge (
    .clk_i,
    .reset_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .rdata_o,
    .err_o,
    .ack_o,
    .intc_sel_o   (intc_sel),
    .gpio_sel_o   (gpio_sel),
    .tmr_sel_o    (tmr_sel),
    .we_o         (periph_we),
    .idx_o        (periph_idx),
    .wdata_o      (periph_wdata),
    .intc_rdata_i (intc_rdata),
    .gpio_rdata_i (gpio_rdata),
    .tmr_rdata_i  (tmr_rdata)
  );

  periph_timer #(
    .TIMER_WIDTH (TIMER_WIDTH)
  ) i_periph_timer (
    .clk_i,
    .reset_i,
    .sel_i     (tmr_sel),
    .we_i      (periph_we),
    .idx_i     (periph_idx),
    .wdata_i   (periph_wdata),
    .rdata_o   (tmr_rdata),
    .expired_o (tmr_expired)
  );

  periph_gpio #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_periph_gpio (
    .clk_i,
    .reset_i,
    .sel_i     (gpio_sel),
    .we_i      (periph_we),
    .idx_i     (periph_idx),
    .wdata_i   (periph_wdata),
    .rdata_o   (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .edge_o    (gpio_edge)
  );

  periph_intc #(
    .NUM_SRC (NUM_SRC)
  ) i_periph_intc (
    .clk_i,
    .reset_i,
    .sel_i   (intc_sel),
    .we_i    (periph_we),
    .idx_i   (periph_idx),
    .wdata_i (periph_wdata),
    .rdata_o (intc_rdata),
    .irq_o,
    .src_i   (intc_src)
  );

endmodule : peripheral_subsystem

/* sim/tb_peripheral_subsystem.sv */
// *********************************************************
// Testbench for the peripheral subsystem: bus handshake,
// GPIO, compare timer and interrupt controller
// *********************************************************

`timescale 1ns/10ps

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  localparam int GPIO_WIDTH  = 8;
  localparam int TIMER_WIDTH = 16;
  localparam int NUM_SRC     = GPIO_WIDTH + 1;
  localparam int MAX_CYCLES  = 4000;

  logic                  clk;
  logic                  reset;
  logic                  req;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  err;
  logic                  ack;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oe;
  logic                  irq;

  int                    errors;
  int                    test_errors;
  int                    tests_run;
  int                    tests_failed;
  int                    cycles;
  integer                seed;
  logic [DATA_WIDTH-1:0] rd;
  logic [DATA_WIDTH-1:0] val;
  logic [DATA_WIDTH-1:0] cmp;
  logic                  rd_err;
  int                    pin;
  int                    other;
  int                    claim;
  int                    wait_cycles;
  logic [GPIO_WIDTH-1:0] pattern;
  logic [NUM_SRC-1:0]    expected;

  peripheral_subsystem #(
    .GPIO_WIDTH  (GPIO_WIDTH),
    .TIMER_WIDTH (TIMER_WIDTH)
  ) i_peripheral_subsystem (
    .clk_i     (clk),
    .reset_i   (reset),
    .req_i     (req),
    .we_i      (we),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .rdata_o   (rdata),
    .err_o     (err),
    .ack_o     (ack),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_o     (irq)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Handshake timing seen from the master
  a_ack_in_time : assert property (@(posedge clk) disable iff (reset)
    $rose(req) |-> ##[1:2] ack)
    else begin
      $display("ack_o did not rise within 2 cycles of req_i");
      errors++;
    end

  a_ack_drops : assert property (@(posedge clk) disable iff (reset)
    $fell(req) |=> !ack)
    else begin
      $display("ack_o still high one cycle after req_i fell");
      errors++;
    end

  function automatic logic [ADDR_WIDTH-1:0] reg_addr(input logic [3:0] sel,
                                                     input reg_idx_t idx);
    return {sel, idx, 2'b00};
  endfunction

  // Source number plus one of the lowest set bit, zero if none
  function automatic int lowest_claim(input logic [NUM_SRC-1:0] vec);
    for (int i = 0; i < NUM_SRC; i++) begin
      if (vec[i]) begin
        return i + 1;
      end
    end
    return 0;
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
    assert (got === exp)
      else begin
        $display("** Error: %s = %h, expected %h", name, got, exp);
        errors++;
      end
  endtask

  task automatic bus_access(input logic write, input logic [ADDR_WIDTH-1:0] a,
                            input logic [DATA_WIDTH-1:0] d,
                            output logic [DATA_WIDTH-1:0] q, output logic e);
    @(posedge clk);
    #2;
    req   = 1'b1;
    we    = write;
    addr  = a;
    wdata = d;
    @(posedge clk);
    while (!ack) begin
      @(posedge clk);
    end
    q = rdata;
    e = err;
    #2;
    req = 1'b0;
    @(posedge clk);
    while (ack) begin
      @(posedge clk);
    end
  endtask

  task automatic bus_write(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d);
    logic [DATA_WIDTH-1:0] q;
    logic                  e;
    bus_access(1'b1, a, d, q, e);
    check_value("err_o", e, 0);
  endtask

  task automatic bus_read(input logic [ADDR_WIDTH-1:0] a, output logic [DATA_WIDTH-1:0] q);
    logic e;
    bus_access(1'b0, a, '0, q, e);
    check_value("err_o", e, 0);
  endtask

  task automatic drive_pins(input logic [GPIO_WIDTH-1:0] value);
    @(posedge clk);
    #2;
    gpio_in = value;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %-16s pass", name);
    end else begin
      tests_failed++;
      $display("test %-16s fail (%0d errors)", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    gpio_in      = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    seed         = 59557;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    check_value("ack_o", ack, 0);
    check_value("irq_o", irq, 0);
    check_value("gpio_oe_o", gpio_oe, 0);
    bus_read(reg_addr(SEL_INTC, REG_INTC_ENABLE), rd);
    check_value("intc enable", rd, 0);
    end_test("reset");

    repeat (3) begin
      val = $random(seed);
      bus_write(reg_addr(SEL_GPIO, REG_GPIO_OUT), val);
      check_value("gpio_o", gpio_out, val[GPIO_WIDTH-1:0]);
      val = $random(seed);
      bus_write(reg_addr(SEL_GPIO, REG_GPIO_OE), val);
      check_value("gpio_oe_o", gpio_oe, val[GPIO_WIDTH-1:0]);
      drive_pins($random(seed));
      repeat (2) @(posedge clk);
      bus_read(reg_addr(SEL_GPIO, REG_GPIO_IN), rd);
      check_value("gpio in", rd, gpio_in);
    end
    // Select field 3 is not mapped
    bus_access(1'b0, 8'h30, '0, rd, rd_err);
    check_value("err_o", rd_err, 1);
    check_value("rdata_o", rd, 0);
    end_test("gpio");

    cmp = 6 + ($random(seed) & 15);
    bus_write(reg_addr(SEL_GPIO, REG_GPIO_IRQ_EN), 0);
    bus_write(reg_addr(SEL_TIMER, REG_TMR_CMP), cmp);
    bus_write(reg_addr(SEL_TIMER, REG_TMR_CTRL), 1);
    repeat (4) begin
      bus_read(reg_addr(SEL_TIMER, REG_TMR_COUNT), rd);
      assert (rd <= cmp)
        else begin
          $display("** Error: timer count = %h, above compare %h", rd, cmp);
          errors++;
        end
    end
    bus_write(reg_addr(SEL_INTC, REG_INTC_ENABLE), 1);
    bus_write(reg_addr(SEL_INTC, REG_INTC_PENDING), '1);
    wait_cycles = 0;
    while (!irq && wait_cycles <= cmp + 3) begin
      @(posedge clk);
      wait_cycles++;
    end
    assert (irq)
      else begin
        $display("irq_o did not rise within %0d cycles of the timer expiry", cmp + 3);
        errors++;
      end
    bus_read(reg_addr(SEL_INTC, REG_INTC_CLAIM), rd);
    check_value("claim", rd, 1);
    bus_write(reg_addr(SEL_TIMER, REG_TMR_CTRL), 0);
    end_test("timer");

    drive_pins('0);
    repeat (4) @(posedge clk);
    bus_write(reg_addr(SEL_INTC, REG_INTC_PENDING), '1);
    pin   = $random(seed) & (GPIO_WIDTH - 1);
    other = (pin + 3) % GPIO_WIDTH;
    bus_write(reg_addr(SEL_GPIO, REG_GPIO_IRQ_EN), 32'(1) << pin);
    drive_pins((GPIO_WIDTH'(1) << pin) | (GPIO_WIDTH'(1) << other));
    repeat (6) @(posedge clk);
    bus_read(reg_addr(SEL_INTC, REG_INTC_PENDING), rd);
    check_value("intc pending", rd, 32'(1) << (pin + 1));
    end_test("gpio interrupt");

    drive_pins('0);
    repeat (4) @(posedge clk);
    pattern          = $random(seed) | 8'h05;
    expected         = {pattern, 1'b0};
    expected[pin + 1] = 1'b1;
    bus_write(reg_addr(SEL_GPIO, REG_GPIO_IRQ_EN), 8'hff);
    bus_write(reg_addr(SEL_INTC, REG_INTC_ENABLE), 9'h1ff);
    drive_pins(pattern);
    repeat (6) @(posedge clk);
    bus_read(reg_addr(SEL_INTC, REG_INTC_PENDING), rd);
    check_value("intc pending", rd, expected);
    check_value("irq_o", irq, 1);
    repeat (2) begin
      claim = lowest_claim(expected);
      bus_read(reg_addr(SEL_INTC, REG_INTC_CLAIM), rd);
      check_value("claim", rd, claim);
      expected[claim - 1] = 1'b0;
    end
    bus_read(reg_addr(SEL_INTC, REG_INTC_PENDING), rd);
    check_value("intc pending", rd, expected);
    bus_write(reg_addr(SEL_INTC, REG_INTC_PENDING), '1);
    check_value("irq_o", irq, 0);
    bus_read(reg_addr(SEL_INTC, REG_INTC_PENDING), rd);
    check_value("intc pending", rd, 0);
    end_test("priority");

    $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_peripheral_subsystem

/* tb.f */
source/periph_pkg.sv
source/periph_bridge.sv
source/periph_timer.sv
source/periph_gpio.sv
source/periph_intc.sv
source/peripheral_subsystem.sv
sim/tb_peripheral_subsystem.sv
